//--- src/fifo_cfg_pkg.sv
`default_nettype none

package fifo_cfg_pkg;

   // write side word width in bits
   localparam int DEF_W_DATA_W = 32;

   // read side word width in bits
   localparam int DEF_R_DATA_W = 8;

   // address width in narrow words, so 64 bytes or 16 wide words by default
   localparam int DEF_ADDR_W = 6;

endpackage

`default_nettype wire

//--- src/gray_code_pkg.sv
`default_nettype none

package gray_code_pkg;

   localparam int PTR_MAX_W = 16;

   // pointer word, each side only uses its low bits
   typedef logic [PTR_MAX_W-1:0] ptr_t;

   function automatic ptr_t bin_to_gray(input ptr_t bin);
      return bin ^ (bin >> 1);
   endfunction

   // each binary bit is the xor of all gray bits at or above it
   function automatic ptr_t gray_to_bin(input ptr_t gray);
      ptr_t bin;
      bin[PTR_MAX_W-1] = gray[PTR_MAX_W-1];
      for (int i = PTR_MAX_W - 2; i >= 0; i--) begin
         bin[i] = bin[i+1] ^ gray[i];
      end
      return bin;
   endfunction

endpackage

`default_nettype wire

//--- src/fifo_write_side.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_write_side #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W,
   localparam int MAX_W    = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W    = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int DIFF     = $clog2(MAX_W / MIN_W),
   // a wide side counts in steps of 2**DIFF narrow words
   localparam int W_SHIFT  = (W_DATA_W > R_DATA_W) ? DIFF : 0,
   localparam int R_SHIFT  = (R_DATA_W > W_DATA_W) ? DIFF : 0,
   localparam int W_ADDR_W = ADDR_W - W_SHIFT,
   localparam int R_ADDR_W = ADDR_W - R_SHIFT
) (
   input  logic                 w_clk_i,
   input  logic                 reset_i,
   input  logic                 w_en_i,
   input  gray_code_pkg::ptr_t  rd_ptr_gray_i,
   output gray_code_pkg::ptr_t  wr_ptr_gray_o,
   output logic                 wr_en_o,
   output logic [W_ADDR_W-1:0]  wr_addr_o,
   output logic                 w_empty_o,
   output logic                 w_full_o,
   output logic [ADDR_W:0]      w_level_o
);

   import gray_code_pkg::*;

   localparam int W_PTR_W = W_ADDR_W + 1;
   localparam int R_PTR_W = R_ADDR_W + 1;

   localparam logic [ADDR_W:0] FIFO_SIZE  = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [ADDR_W:0] W_INCR     = (ADDR_W+1)'(1 << W_SHIFT);
   localparam logic [ADDR_W:0] FULL_LIMIT = FIFO_SIZE - W_INCR;

   logic [W_PTR_W-1:0] wr_bin_q;
   logic [W_PTR_W-1:0] wr_bin_next;
   ptr_t               wr_gray_q;

   // two flop synchronizer stages for the read pointer
   ptr_t               rd_gray_s1_q;
   ptr_t               rd_gray_s2_q;
   logic [R_PTR_W-1:0] rd_bin_sync;

   // both pointers scaled to narrow words
   logic [ADDR_W:0]    wr_bin_n;
   logic [ADDR_W:0]    rd_bin_n;

   // writes while full are dropped here
   assign wr_en_o     = w_en_i & ~w_full_o;
   assign wr_bin_next = wr_bin_q + W_PTR_W'(1);

   always_ff @(posedge w_clk_i) begin
      if (reset_i) begin
         wr_bin_q  <= '0;
         wr_gray_q <= '0;
      end else if (wr_en_o) begin
         wr_bin_q  <= wr_bin_next;
         wr_gray_q <= bin_to_gray(ptr_t'(wr_bin_next));
      end
   end

   always_ff @(posedge w_clk_i) begin
      if (reset_i) begin
         rd_gray_s1_q <= '0;
         rd_gray_s2_q <= '0;
      end else begin
         rd_gray_s1_q <= rd_ptr_gray_i;
         rd_gray_s2_q <= rd_gray_s1_q;
      end
   end

   assign rd_bin_sync = R_PTR_W'(gray_to_bin(rd_gray_s2_q));

   assign wr_bin_n = (ADDR_W+1)'(wr_bin_q) << W_SHIFT;
   assign rd_bin_n = (ADDR_W+1)'(rd_bin_sync) << R_SHIFT;

   // level wraps correctly since it never exceeds FIFO_SIZE
   assign w_level_o = wr_bin_n - rd_bin_n;
   assign w_empty_o = (w_level_o < W_INCR);
   assign w_full_o  = (w_level_o > FULL_LIMIT);

   assign wr_addr_o     = wr_bin_q[W_ADDR_W-1:0];
   assign wr_ptr_gray_o = wr_gray_q;

endmodule

`default_nettype wire

//--- src/fifo_read_side.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_read_side #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W,
   localparam int MAX_W    = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W    = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int DIFF     = $clog2(MAX_W / MIN_W),
   localparam int W_SHIFT  = (W_DATA_W > R_DATA_W) ? DIFF : 0,
   localparam int R_SHIFT  = (R_DATA_W > W_DATA_W) ? DIFF : 0,
   localparam int W_ADDR_W = ADDR_W - W_SHIFT,
   localparam int R_ADDR_W = ADDR_W - R_SHIFT
) (
   input  logic                 r_clk_i,
   input  logic                 reset_i,
   input  logic                 r_en_i,
   input  gray_code_pkg::ptr_t  wr_ptr_gray_i,
   output gray_code_pkg::ptr_t  rd_ptr_gray_o,
   output logic                 rd_en_o,
   output logic [R_ADDR_W-1:0]  rd_addr_o,
   output logic                 r_empty_o,
   output logic                 r_full_o,
   output logic [ADDR_W:0]      r_level_o
);

   import gray_code_pkg::*;

   localparam int W_PTR_W = W_ADDR_W + 1;
   localparam int R_PTR_W = R_ADDR_W + 1;

   localparam logic [ADDR_W:0] FIFO_SIZE  = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [ADDR_W:0] R_INCR     = (ADDR_W+1)'(1 << R_SHIFT);
   localparam logic [ADDR_W:0] FULL_LIMIT = FIFO_SIZE - R_INCR;

   logic [R_PTR_W-1:0] rd_bin_q;
   logic [R_PTR_W-1:0] rd_bin_next;
   ptr_t               rd_gray_q;

   // write pointer arrives from the other clock domain
   ptr_t               wr_gray_s1_q;
   ptr_t               wr_gray_s2_q;
   logic [W_PTR_W-1:0] wr_bin_sync;

   logic [ADDR_W:0]    wr_bin_n;
   logic [ADDR_W:0]    rd_bin_n;

   // reads while empty are ignored
   assign rd_en_o     = r_en_i & ~r_empty_o;
   assign rd_bin_next = rd_bin_q + R_PTR_W'(1);

   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         rd_bin_q  <= '0;
         rd_gray_q <= '0;
      end else if (rd_en_o) begin
         rd_bin_q  <= rd_bin_next;
         rd_gray_q <= bin_to_gray(ptr_t'(rd_bin_next));
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         wr_gray_s1_q <= '0;
         wr_gray_s2_q <= '0;
      end else begin
         wr_gray_s1_q <= wr_ptr_gray_i;
         wr_gray_s2_q <= wr_gray_s1_q;
      end
   end

   assign wr_bin_sync = W_PTR_W'(gray_to_bin(wr_gray_s2_q));

   // scale to narrow words before comparing
   assign wr_bin_n = (ADDR_W+1)'(wr_bin_sync) << W_SHIFT;
   assign rd_bin_n = (ADDR_W+1)'(rd_bin_q) << R_SHIFT;

   assign r_level_o = wr_bin_n - rd_bin_n;
   assign r_empty_o = (r_level_o < R_INCR);
   assign r_full_o  = (r_level_o > FULL_LIMIT);

   assign rd_addr_o     = rd_bin_q[R_ADDR_W-1:0];
   assign rd_ptr_gray_o = rd_gray_q;

endmodule

`default_nettype wire

//--- src/fifo_dual_clock_ram.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_dual_clock_ram #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W,
   localparam int MAX_W    = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W,
   localparam int MIN_W    = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W,
   localparam int RATIO    = MAX_W / MIN_W,
   localparam int DIFF     = $clog2(RATIO),
   localparam int W_ADDR_W = (W_DATA_W > R_DATA_W) ? ADDR_W - DIFF : ADDR_W,
   localparam int R_ADDR_W = (R_DATA_W > W_DATA_W) ? ADDR_W - DIFF : ADDR_W
) (
   input  logic                 w_clk_i,
   input  logic                 r_clk_i,
   input  logic                 reset_i,
   input  logic                 wr_en_i,
   input  logic [W_ADDR_W-1:0]  wr_addr_i,
   input  logic [W_DATA_W-1:0]  wr_data_i,
   input  logic                 rd_en_i,
   input  logic [R_ADDR_W-1:0]  rd_addr_i,
   output logic [R_DATA_W-1:0]  rd_data_o
);

   localparam int ROW_A_W = ADDR_W - DIFF;
   localparam int ROWS    = 1 << ROW_A_W;

   // one row seen whole by the wide side or lane by lane by the narrow side
   typedef union packed {
      logic [MAX_W-1:0]            word;
      logic [RATIO-1:0][MIN_W-1:0] lane;
   } row_t;

   row_t mem [ROWS];

   // lane 0 sits in the low bits of a row
   generate
      if (W_DATA_W < R_DATA_W) begin : g_wr_lane
         always_ff @(posedge w_clk_i) begin
            if (wr_en_i) begin
               mem[wr_addr_i[W_ADDR_W-1:DIFF]].lane[wr_addr_i[DIFF-1:0]] <= wr_data_i;
            end
         end
      end else begin : g_wr_word
         always_ff @(posedge w_clk_i) begin
            if (wr_en_i) begin
               mem[wr_addr_i].word <= wr_data_i;
            end
         end
      end
   endgenerate

   // registered read, holds until the next accepted read
   generate
      if (R_DATA_W < W_DATA_W) begin : g_rd_lane
         always_ff @(posedge r_clk_i) begin
            if (reset_i) begin
               rd_data_o <= '0;
            end else if (rd_en_i) begin
               rd_data_o <= mem[rd_addr_i[R_ADDR_W-1:DIFF]].lane[rd_addr_i[DIFF-1:0]];
            end
         end
      end else begin : g_rd_word
         always_ff @(posedge r_clk_i) begin
            if (reset_i) begin
               rd_data_o <= '0;
            end else if (rd_en_i) begin
               rd_data_o <= mem[rd_addr_i].word;
            end
         end
      end
   endgenerate

endmodule

`default_nettype wire

//--- src/async_fifo_top.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_top #(
   parameter int W_DATA_W = fifo_cfg_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = fifo_cfg_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = fifo_cfg_pkg::DEF_ADDR_W
) (
   input  logic                w_clk_i,
   input  logic                r_clk_i,
   input  logic                reset_i,

   // write port
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   output logic                w_empty_o,
   output logic                w_full_o,
   output logic [ADDR_W:0]     w_level_o,

   // read port
   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_empty_o,
   output logic                r_full_o,
   output logic [ADDR_W:0]     r_level_o
);

   import gray_code_pkg::*;

   localparam int MAX_W    = (W_DATA_W > R_DATA_W) ? W_DATA_W : R_DATA_W;
   localparam int MIN_W    = (W_DATA_W > R_DATA_W) ? R_DATA_W : W_DATA_W;
   localparam int DIFF     = $clog2(MAX_W / MIN_W);
   localparam int W_ADDR_W = (W_DATA_W > R_DATA_W) ? ADDR_W - DIFF : ADDR_W;
   localparam int R_ADDR_W = (R_DATA_W > W_DATA_W) ? ADDR_W - DIFF : ADDR_W;

   logic                wr_en;
   logic [W_ADDR_W-1:0] wr_addr;
   logic                rd_en;
   logic [R_ADDR_W-1:0] rd_addr;

   // gray pointers crossing between the clock domains
   ptr_t                wr_ptr_gray;
   ptr_t                rd_ptr_gray;

   fifo_write_side #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_write_side (
      .w_clk_i       (w_clk_i),
      .reset_i       (reset_i),
      .w_en_i        (w_en_i),
      .rd_ptr_gray_i (rd_ptr_gray),
      .wr_ptr_gray_o (wr_ptr_gray),
      .wr_en_o       (wr_en),
      .wr_addr_o     (wr_addr),
      .w_empty_o     (w_empty_o),
      .w_full_o      (w_full_o),
      .w_level_o     (w_level_o)
   );

   fifo_dual_clock_ram #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_ram (
      .w_clk_i   (w_clk_i),
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .wr_en_i   (wr_en),
      .wr_addr_i (wr_addr),
      .wr_data_i (w_data_i),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (r_data_o)
   );

   fifo_read_side #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_read_side (
      .r_clk_i       (r_clk_i),
      .reset_i       (reset_i),
      .r_en_i        (r_en_i),
      .wr_ptr_gray_i (wr_ptr_gray),
      .rd_ptr_gray_o (rd_ptr_gray),
      .rd_en_o       (rd_en),
      .rd_addr_o     (rd_addr),
      .r_empty_o     (r_empty_o),
      .r_full_o      (r_full_o),
      .r_level_o     (r_level_o)
   );

endmodule

`default_nettype wire

//--- sim/async_fifo_tests.svh
`ifndef ASYNC_FIFO_TESTS_SVH
`define ASYNC_FIFO_TESTS_SVH

// narrow words the read side should return, oldest first
logic [R_DATA_W-1:0] model_q[$];
logic [R_DATA_W-1:0] last_read = '0;

// the lowest lane of a wide word comes out first
task automatic push_word(input logic [W_DATA_W-1:0] word);
   for (int i = 0; i < LANES; i++) begin
      model_q.push_back(word[i*R_DATA_W +: R_DATA_W]);
   end
endtask

task automatic pop_expected(output logic [R_DATA_W-1:0] exp);
   assert (model_q.size() > 0)
      else stop_run("a read was accepted while the reference model was empty");
   exp = model_q.pop_front();
endtask

function automatic logic [W_DATA_W-1:0] fill_word(input int idx);
   logic [W_DATA_W-1:0] word;
   for (int l = 0; l < LANES; l++) begin
      word[l*R_DATA_W +: R_DATA_W] = R_DATA_W'(idx * LANES + l);
   end
   return word;
endfunction

// starts and ends just after a write clock edge
task automatic write_word(input logic [W_DATA_W-1:0] word, input logic accepted);
   w_en   = 1'b1;
   w_data = word;
   if (accepted) begin
      push_word(word);
   end
   sync_w();
   w_en = 1'b0;
endtask

task automatic read_and_check();
   logic [R_DATA_W-1:0] exp;
   assert (!r_empty) else report_mismatch("r_empty_o high while the model holds data");
   pop_expected(exp);
   r_en = 1'b1;
   sync_r();
   r_en = 1'b0;
   assert (r_data == exp)
      else report_mismatch($sformatf("r_data_o is %h, expected %h", r_data, exp));
   last_read = exp;
endtask

task automatic check_after_reset();
   sync_r();
   assert (r_empty && !r_full) else report_mismatch("read side flags wrong after reset");
   assert (r_level == '0 && r_data == '0)
      else report_mismatch("r_level_o or r_data_o not zero after reset");
   sync_w();
   assert (w_empty && !w_full && w_level == '0)
      else report_mismatch("write side flags or level wrong after reset");
endtask

task automatic check_one_word();
   sync_w();
   write_word(W_DATA_W'(32'ha1b2_c3d4), 1'b1);
   settle();
   assert (int'(r_level) == LANES)
      else report_mismatch($sformatf("r_level_o is %0d, expected %0d", r_level, LANES));
   sync_w();
   assert (int'(w_level) == LANES)
      else report_mismatch($sformatf("w_level_o is %0d, expected %0d", w_level, LANES));
   sync_r();
   repeat (LANES) read_and_check();
   assert (r_empty) else report_mismatch("r_empty_o low after the last byte was read");
   settle();
   sync_w();
   assert (w_empty) else report_mismatch("w_empty_o low after the read side drained");
endtask

task automatic check_fill_to_full();
   sync_w();
   for (int i = 0; i < FIFO_SIZE / LANES; i++) begin
      write_word(fill_word(i), 1'b1);
   end
   assert (w_full && int'(w_level) == FIFO_SIZE)
      else report_mismatch($sformatf("w_full_o %b with w_level_o %0d", w_full, w_level));
   // this word must be dropped
   write_word(W_DATA_W'(32'hdead_beef), 1'b0);
   settle();
   assert (r_full && int'(r_level) == FIFO_SIZE)
      else report_mismatch($sformatf("r_full_o %b with r_level_o %0d", r_full, r_level));
   while (model_q.size() > 0) begin
      read_and_check();
   end
   settle();
   assert (r_empty && r_level == '0)
      else report_mismatch("data is left after the drain, so the dropped word was stored");
endtask

task automatic check_read_while_empty();
   sync_r();
   assert (r_empty) else report_mismatch("r_empty_o low before the empty read");
   r_en = 1'b1;
   sync_r();
   r_en = 1'b0;
   sync_r();
   assert (r_data == last_read && r_level == '0)
      else report_mismatch($sformatf("r_data_o %h r_level_o %0d after an empty read",
                                     r_data, r_level));
endtask

task automatic check_random_stream();
   logic                done;
   logic                pending;
   logic [R_DATA_W-1:0] exp;
   logic [W_DATA_W-1:0] word;
   done    = 1'b0;
   pending = 1'b0;
   exp     = '0;
   fork
      begin
         sync_w();
         repeat (STREAM_CYCLES) begin
            if (next_random_bit() && !w_full) begin
               word   = W_DATA_W'(random_word(W_DATA_W));
               w_en   = 1'b1;
               w_data = word;
               push_word(word);
            end else begin
               w_en = 1'b0;
            end
            sync_w();
         end
         w_en = 1'b0;
         done = 1'b1;
      end
      begin
         while (!done || pending) begin
            sync_r();
            if (pending) begin
               assert (r_data == exp)
                  else report_mismatch($sformatf("stream byte %h, expected %h", r_data, exp));
               last_read = exp;
            end
            pending = 1'b0;
            r_en    = 1'b0;
            if (!done && next_random_bit() && !r_empty) begin
               pop_expected(exp);
               r_en    = 1'b1;
               pending = 1'b1;
            end
         end
      end
   join
   settle();
   while (model_q.size() > 0) begin
      read_and_check();
   end
   assert (r_empty) else report_mismatch("r_empty_o low after the final drain");
endtask

`endif

//--- sim/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

   import fifo_cfg_pkg::*;

   localparam int W_DATA_W  = DEF_W_DATA_W;
   localparam int R_DATA_W  = DEF_R_DATA_W;
   localparam int ADDR_W    = DEF_ADDR_W;
   localparam int LANES     = W_DATA_W / R_DATA_W;
   localparam int FIFO_SIZE = 1 << ADDR_W;

   localparam int W_HALF_NS     = 2;
   localparam int R_HALF_NS     = 3;
   localparam int R_PHASE_NS    = 1;
   localparam int DRIVE_DELAY   = 1;
   localparam int RESET_CYCLES  = 5;
   localparam int SETTLE_CYCLES = 5;
   localparam int STREAM_CYCLES = 200;
   // the random stream and two full drains take about 500 write cycles
   localparam int WATCHDOG_CYCLES = 2000;

   logic                w_clk;
   logic                r_clk;
   logic                reset;
   logic                w_en;
   logic [W_DATA_W-1:0] w_data;
   logic                w_empty;
   logic                w_full;
   logic [ADDR_W:0]     w_level;
   logic                r_en;
   logic [R_DATA_W-1:0] r_data;
   logic                r_empty;
   logic                r_full;
   logic [ADDR_W:0]     r_level;

   logic [31:0]         lfsr_state = 32'h966f_04ae;

   async_fifo_top #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_dut (
      .w_clk_i   (w_clk),
      .r_clk_i   (r_clk),
      .reset_i   (reset),
      .w_en_i    (w_en),
      .w_data_i  (w_data),
      .w_empty_o (w_empty),
      .w_full_o  (w_full),
      .w_level_o (w_level),
      .r_en_i    (r_en),
      .r_data_o  (r_data),
      .r_empty_o (r_empty),
      .r_full_o  (r_full),
      .r_level_o (r_level)
   );

   initial begin
      w_clk = 1'b0;
      forever #(W_HALF_NS) w_clk = ~w_clk;
   end

   // phase offset keeps read edges away from the write side drive times
   initial begin
      r_clk = 1'b0;
      #(R_PHASE_NS);
      forever #(R_HALF_NS) r_clk = ~r_clk;
   end

   // fibonacci lfsr with taps 32, 22, 2 and 1
   function automatic logic next_random_bit();
      logic fb;
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] random_word(input int n_bits);
      logic [31:0] word;
      word = '0;
      for (int i = 0; i < n_bits; i++) begin
         word = {word[30:0], next_random_bit()};
      end
      return word;
   endfunction

   task automatic stop_run(input string reason);
      $display("%s", reason);
      $display("Some tests failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic report_mismatch(input string what);
      stop_run($sformatf("FAILED at %0d ns: %s", $time, what));
   endtask

   // each domain is driven and sampled just after its own rising edge
   task automatic sync_w();
      @(posedge w_clk);
      #(DRIVE_DELAY);
   endtask

   task automatic sync_r();
      @(posedge r_clk);
      #(DRIVE_DELAY);
   endtask

   task automatic settle();
      repeat (SETTLE_CYCLES) sync_r();
   endtask

   `include "async_fifo_tests.svh"

   initial begin
      reset  = 1'b1;
      w_en   = 1'b0;
      w_data = '0;
      r_en   = 1'b0;
      repeat (RESET_CYCLES) @(posedge w_clk);
      #(DRIVE_DELAY);
      reset = 1'b0;

      check_after_reset();
      check_one_word();
      check_fill_to_full();
      check_read_while_empty();
      check_random_stream();

      $display("All tests passed");
      $finish;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge w_clk);
      stop_run("watchdog timeout: the tests did not finish in the allowed time");
   end

endmodule

`default_nettype wire

//--- sim.f
+incdir+sim
src/fifo_cfg_pkg.sv
src/gray_code_pkg.sv
src/fifo_write_side.sv
src/fifo_read_side.sv
src/fifo_dual_clock_ram.sv
src/async_fifo_top.sv
sim/async_fifo_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= async_fifo_tb
RTL_TOP   ?= async_fifo_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed

SRCS     := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
RTL_SRCS := $(filter src/%,$(SRCS))
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(SRCS) sim/async_fifo_tests.svh
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
